/* common/fsab_consts.svh */
`ifndef FSAB_CONSTS_SVH
`define FSAB_CONSTS_SVH

// bus beat fields
`define FSAB_DATA_W     64
`define FSAB_ADDR_W     16
`define FSAB_DID_W      8
`define FSAB_LEN_W      4
`define FSAB_MASK_W     8
`define FSAB_BURST_LEN  8
`define FSAB_BEAT_W     3
`define FSAB_PRELOAD_DID 8'hff

// credit loop and target buffer depth in bursts
`define FSAB_CREDITS    2
`define FSAB_CREDIT_W   2
`define TGT_FIFO_AW     4

// storage
`define ROM_WORDS       64
`define ROM_AW          6
`define MEM_WORDS       256
`define MEM_AW          8

// register block
`define REG_AW          2
`define REG_DATA_W      32
`define BURST_CNT_W     4

`endif

/* common/fsab_pkg.sv */
`include "fsab_consts.svh"

package fsab_pkg;

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	// one bus beat
	typedef struct packed {
		logic                      valid;
		fsab_mode_e                mode;
		logic [`FSAB_DID_W-1:0]    did;
		logic [`FSAB_DID_W-1:0]    subdid;
		logic [`FSAB_ADDR_W-1:0]   addr;
		logic [`FSAB_LEN_W-1:0]    len;
		logic [`FSAB_DATA_W-1:0]   data;
		logic [`FSAB_MASK_W-1:0]   mask;
	} fsab_req_t;

	typedef struct packed {
		logic [`REG_AW-1:0]        addr;
		logic [`REG_DATA_W-1:0]    data;
	} reg_wr_t;

	typedef struct packed {
		logic [`MEM_AW-1:0]        addr;
	} rd_req_t;

	typedef struct packed {
		logic [`ROM_AW-1:0]        addr;
		logic [`FSAB_DATA_W-1:0]   data;
	} img_wr_t;

endpackage

/* hdl/boot_rom.sv */
`timescale 1ns/1ps
`include "fsab_consts.svh"

module boot_rom
	import fsab_pkg::*;
(
	input  logic                     clk,
	input  logic                     Nrst,
	input  logic                     img_valid,
	input  img_wr_t                  img_wr,
	output logic                     img_ready,
	input  logic [`ROM_AW-1:0]       rd_addr,
	output logic [`FSAB_DATA_W-1:0]  rd_data
);

	logic [`FSAB_DATA_W-1:0] mem [0:`ROM_WORDS-1];

	// load port opens once reset is released
	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			img_ready <= 1'b0;
		end else begin
			img_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (img_valid && img_ready) begin
			mem[img_wr.addr] <= img_wr.data;
		end
		// one cycle read latency for the engine
		rd_data <= mem[rd_addr];
	end

endmodule

/* hdl/boot_subsystem.sv */
`timescale 1ns/1ps
`include "fsab_consts.svh"

module boot_subsystem
	import fsab_pkg::*;
(
	input  logic                     clk,
	input  logic                     Nrst,
	input  logic                     reg_valid,
	input  reg_wr_t                  reg_wr,
	output logic                     reg_ready,
	input  logic                     img_valid,
	input  img_wr_t                  img_wr,
	output logic                     img_ready,
	input  logic                     rd_valid,
	input  rd_req_t                  rd_req,
	output logic                     rd_ready,
	output logic                     rdata_valid,
	output logic [`FSAB_DATA_W-1:0]  rdata,
	output logic                     core_rst_n
);

	logic [`FSAB_ADDR_W-1:0]  base_addr;
	logic [`BURST_CNT_W-1:0]  burst_count;
	logic                     start;
	logic [`ROM_AW-1:0]       rom_addr;
	logic [`FSAB_DATA_W-1:0]  rom_data;
	fsab_req_t                bus_req;
	logic                     bus_credit;

	preload_cfg cfg_i (
		.clk(clk), .Nrst(Nrst),
		.reg_valid(reg_valid), .reg_wr(reg_wr), .reg_ready(reg_ready),
		.base_addr(base_addr), .burst_count(burst_count), .start(start)
	);

	boot_rom rom_i (
		.clk(clk), .Nrst(Nrst),
		.img_valid(img_valid), .img_wr(img_wr), .img_ready(img_ready),
		.rd_addr(rom_addr), .rd_data(rom_data)
	);

	preload_engine engine_i (
		.clk(clk), .Nrst(Nrst),
		.start(start), .base_addr(base_addr), .burst_count(burst_count),
		.rom_addr(rom_addr), .rom_data(rom_data),
		.bus_req(bus_req), .bus_credit(bus_credit),
		.core_rst_n(core_rst_n)
	);

	fsab_mem_target target_i (
		.clk(clk), .Nrst(Nrst),
		.bus_req(bus_req), .bus_credit(bus_credit),
		.rd_valid(rd_valid), .rd_req(rd_req), .rd_ready(rd_ready),
		.rdata_valid(rdata_valid), .rdata(rdata)
	);

endmodule

/* hdl/fsab_mem_target.sv */
`timescale 1ns/1ps
`include "fsab_consts.svh"

module fsab_mem_target
	import fsab_pkg::*;
(
	input  logic                     clk,
	input  logic                     Nrst,
	input  fsab_req_t                bus_req,
	output logic                     bus_credit,
	input  logic                     rd_valid,
	input  rd_req_t                  rd_req,
	output logic                     rd_ready,
	output logic                     rdata_valid,
	output logic [`FSAB_DATA_W-1:0]  rdata
);

	localparam int FIFO_DEPTH = `FSAB_CREDITS * `FSAB_BURST_LEN;

	logic [`MEM_AW-1:0]       fifo_addr [0:FIFO_DEPTH-1];
	logic [`FSAB_DATA_W-1:0]  fifo_data [0:FIFO_DEPTH-1];
	logic [`FSAB_DATA_W-1:0]  ram [0:`MEM_WORDS-1];
	logic [`TGT_FIFO_AW:0]    wr_ptr;
	logic [`TGT_FIFO_AW:0]    rd_ptr;
	logic [`FSAB_BEAT_W-1:0]  drain_cnt;
	logic                     push;
	logic                     fifo_empty;
	logic                     rd_acc;
	logic                     drain;

	assign push = bus_req.valid && (bus_req.mode == FSAB_WRITE);
	assign fifo_empty = (wr_ptr == rd_ptr);
	assign rd_acc = rd_valid & rd_ready;
	// readback owns the RAM port whenever it is accepted
	assign drain = ~rd_acc & ~fifo_empty;

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			rd_ready <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			drain_cnt <= '0;
			bus_credit <= 1'b0;
			rdata_valid <= 1'b0;
		end else begin
			rd_ready <= 1'b1;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (drain) begin
				rd_ptr <= rd_ptr + 1'b1;
				drain_cnt <= drain_cnt + 1'b1;
			end
			// a burst is retired with its last word in RAM
			bus_credit <= drain && (drain_cnt == {`FSAB_BEAT_W{1'b1}});
			rdata_valid <= rd_acc;
		end
	end

	// occupancy is bounded by the outstanding credits
	always_ff @(posedge clk) begin
		if (push) begin
			fifo_addr[wr_ptr[`TGT_FIFO_AW-1:0]] <= bus_req.addr[`MEM_AW+2:3];
			fifo_data[wr_ptr[`TGT_FIFO_AW-1:0]] <= bus_req.data;
		end
	end

	// single port RAM
	always_ff @(posedge clk) begin
		if (drain)
			ram[fifo_addr[rd_ptr[`TGT_FIFO_AW-1:0]]] <= fifo_data[rd_ptr[`TGT_FIFO_AW-1:0]];
		else if (rd_acc)
			rdata <= ram[rd_req.addr];
	end

endmodule

/* preload/preload_cfg.sv */
`timescale 1ns/1ps
`include "fsab_consts.svh"

module preload_cfg
	import fsab_pkg::*;
(
	input  logic                     clk,
	input  logic                     Nrst,
	input  logic                     reg_valid,
	input  reg_wr_t                  reg_wr,
	output logic                     reg_ready,
	output logic [`FSAB_ADDR_W-1:0]  base_addr,
	output logic [`BURST_CNT_W-1:0]  burst_count,
	output logic                     start
);

	logic reg_acc;
	logic go_seen;

	assign reg_ready = 1'b1;
	assign reg_acc = reg_valid & reg_ready;

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			base_addr <= '0;
			burst_count <= '0;
			start <= 1'b0;
			go_seen <= 1'b0;
		end else begin
			start <= 1'b0;
			if (reg_acc) begin
				case (reg_wr.addr)
					// base is forced to a word boundary
					2'd0: base_addr <= {reg_wr.data[`FSAB_ADDR_W-1:3], 3'b000};
					2'd1: burst_count <= reg_wr.data[`BURST_CNT_W-1:0];
					2'd2: begin
						// only the first go after reset counts
						start <= ~go_seen;
						go_seen <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* preload/preload_engine.sv */
`timescale 1ns/1ps
`include "fsab_consts.svh"

module preload_engine
	import fsab_pkg::*;
(
	input  logic                     clk,
	input  logic                     Nrst,
	input  logic                     start,
	input  logic [`FSAB_ADDR_W-1:0]  base_addr,
	input  logic [`BURST_CNT_W-1:0]  burst_count,
	output logic [`ROM_AW-1:0]       rom_addr,
	input  logic [`FSAB_DATA_W-1:0]  rom_data,
	output fsab_req_t                bus_req,
	input  logic                     bus_credit,
	output logic                     core_rst_n
);

	localparam logic [`FSAB_CREDIT_W-1:0] CREDITS_INIT = `FSAB_CREDITS;

	logic [`FSAB_CREDIT_W-1:0] credits;
	logic                      active;
	logic                      in_burst;
	logic [`ROM_AW:0]          rd_idx;
	logic [`ROM_AW:0]          total_words;
	logic                      run;
	logic                      issue_done;
	logic                      burst_go;
	logic                      rd_en;
	logic                      pipe_valid;
	logic [`ROM_AW-1:0]        pipe_idx;
	logic                      beat_valid;
	fsab_req_t                 beat_q;

	assign total_words = {burst_count, {`FSAB_BEAT_W{1'b0}}};
	// the start cycle already issues the first read
	assign run = active | start;
	assign issue_done = (rd_idx == total_words);
	assign burst_go = run & ~in_burst & ~issue_done & (credits != '0);
	assign rd_en = burst_go | in_burst;
	assign rom_addr = rd_idx[`ROM_AW-1:0];

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			credits <= CREDITS_INIT;
			active <= 1'b0;
			in_burst <= 1'b0;
			rd_idx <= '0;
			pipe_valid <= 1'b0;
			beat_valid <= 1'b0;
			core_rst_n <= 1'b0;
		end else begin
			credits <= credits + {{(`FSAB_CREDIT_W-1){1'b0}}, bus_credit}
				- {{(`FSAB_CREDIT_W-1){1'b0}}, burst_go};
			if (start)
				active <= 1'b1;
			if (burst_go)
				in_burst <= 1'b1;
			else if (in_burst && rd_idx[`FSAB_BEAT_W-1:0] == {`FSAB_BEAT_W{1'b1}})
				in_burst <= 1'b0;
			if (rd_en)
				rd_idx <= rd_idx + 1'b1;
			pipe_valid <= rd_en;
			beat_valid <= pipe_valid;
			// image is in memory once all beats left and every burst retired
			if (active && issue_done && !pipe_valid && !beat_valid && credits == CREDITS_INIT)
				core_rst_n <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		pipe_idx <= rd_idx[`ROM_AW-1:0];
		if (pipe_valid) begin
			beat_q.valid <= 1'b1;
			beat_q.mode <= FSAB_WRITE;
			beat_q.did <= `FSAB_PRELOAD_DID;
			beat_q.subdid <= '0;
			beat_q.addr <= base_addr
				+ {{(`FSAB_ADDR_W-`ROM_AW-3){1'b0}}, pipe_idx, 3'b000};
			beat_q.len <= `FSAB_LEN_W'(`FSAB_BURST_LEN);
			beat_q.data <= rom_data;
			beat_q.mask <= {`FSAB_MASK_W{1'b1}};
		end
	end

	always_comb begin
		bus_req = beat_q;
		bus_req.valid = beat_valid;
	end

endmodule

/* project.f */
+incdir+common
common/fsab_pkg.sv
preload/preload_cfg.sv
hdl/boot_rom.sv
preload/preload_engine.sv
hdl/fsab_mem_target.sv
hdl/boot_subsystem.sv
testbench/boot_subsystem_checker.sv
testbench/boot_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module boot_subsystem_tb \
	-f project.f -o sim_boot
./obj_dir/sim_boot > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

/* testbench/boot_stim.txt */
// first value: number of tests; then per test a header line and a check line
// header: base byte address, burst count, readback during preload, image pattern
// image word i is the pattern plus i
// check: four pairs of RAM word address and expected word
3
0000 1 0 1111222233334400
00 1111222233334400 07 1111222233334407 03 1111222233334403 05 1111222233334405
0100 8 0 a5a50000c3c31000
20 a5a50000c3c31000 3f a5a50000c3c3101f 40 a5a50000c3c31020 5f a5a50000c3c3103f
0400 4 1 0123456789abcd00
80 0123456789abcd00 88 0123456789abcd08 90 0123456789abcd10 9f 0123456789abcd1f

/* testbench/boot_subsystem_checker.sv */
`timescale 1ns/1ps
`include "fsab_consts.svh"

module boot_subsystem_checker (
	input logic                      clk,
	input logic                      Nrst,
	input logic [`FSAB_CREDIT_W-1:0] credits,
	input logic                      burst_go,
	input logic                      beat_valid,
	input logic                      bus_credit,
	input logic                      core_rst_n
);

	// burst starts of the last nine cycles with bit 0 the newest
	logic [8:0] go_hist;
	// bursts seen on the bus and not yet retired
	logic [`FSAB_CREDIT_W:0] in_flight;
	logic [`FSAB_BEAT_W-1:0] beat_idx;
	logic                    first_beat;

	assign first_beat = beat_valid && (beat_idx == '0);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			go_hist <= '0;
			beat_idx <= '0;
			in_flight <= '0;
		end else begin
			go_hist <= {go_hist[7:0], burst_go};
			if (beat_valid)
				beat_idx <= beat_idx + 1'b1;
			in_flight <= in_flight + {{`FSAB_CREDIT_W{1'b0}}, first_beat}
				- {{`FSAB_CREDIT_W{1'b0}}, bus_credit};
		end
	end

	credit_limit: assert property (@(posedge clk) disable iff (!Nrst)
		credits <= `FSAB_CREDITS)
		else $error("credit count above its initial value");

	credit_spend: assert property (@(posedge clk) disable iff (!Nrst)
		in_flight <= `FSAB_CREDITS)
		else $error("burst sent without a credit");

	// bursts never overlap
	burst_spacing: assert property (@(posedge clk) disable iff (!Nrst)
		burst_go |-> go_hist[6:0] == '0)
		else $error("burst started before the previous one finished");

	// valid for exactly the 8 cycles from 2 to 9 after a burst start
	burst_beats: assert property (@(posedge clk) disable iff (!Nrst)
		beat_valid == |go_hist[8:1])
		else $error("bus valid does not match an 8 beat burst");

	core_release: assert property (@(posedge clk) disable iff (!Nrst)
		core_rst_n |=> core_rst_n)
		else $error("core reset asserted again after release");

endmodule

bind preload_engine boot_subsystem_checker checker_i (
	.clk(clk), .Nrst(Nrst), .credits(credits), .burst_go(burst_go),
	.beat_valid(bus_req.valid), .bus_credit(bus_credit), .core_rst_n(core_rst_n)
);

/* testbench/boot_subsystem_tb.sv */
`timescale 1ns/1ps
`include "fsab_consts.svh"

module boot_subsystem_tb
	import fsab_pkg::*;
;

	localparam int STIM_LEN = 37;
	localparam int REC_LEN = 12;

	logic clk = 1'b0;
	logic Nrst;
	logic reg_valid, reg_ready, img_valid, img_ready, rd_valid, rd_ready;
	logic rdata_valid, core_rst_n;
	logic [`FSAB_DATA_W-1:0] rdata;
	reg_wr_t reg_wr;
	img_wr_t img_wr;
	rd_req_t rd_req;

	logic [`FSAB_DATA_W-1:0] stim [0:STIM_LEN-1];
	int errors = 0;
	int test_errors = 0;
	int checks = 0;
	int tests_failed = 0;
	int accepted_cnt = 0;
	int rdv_count = 0;
	int flood_reads = 0;
	int wd_cycles = 0;

	boot_subsystem boot_subsystem_i (
		.clk(clk), .Nrst(Nrst),
		.reg_valid(reg_valid), .reg_wr(reg_wr), .reg_ready(reg_ready),
		.img_valid(img_valid), .img_wr(img_wr), .img_ready(img_ready),
		.rd_valid(rd_valid), .rd_req(rd_req), .rd_ready(rd_ready),
		.rdata_valid(rdata_valid), .rdata(rdata), .core_rst_n(core_rst_n)
	);

	always #10 clk = ~clk;

	// one pulse expected per accepted readback
	always @(negedge clk) begin
		if (Nrst && rdata_valid)
			rdv_count++;
	end

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	// image word i is the test pattern plus i
	function automatic logic [63:0] image_word(input logic [63:0] pattern, input int i);
		return pattern + 64'(i);
	endfunction

	task automatic apply_reset();
		Nrst = 1'b0;
		reg_valid = 1'b0;
		img_valid = 1'b0;
		rd_valid = 1'b0;
		reg_wr = '0;
		img_wr = '0;
		rd_req = '0;
		repeat (10) @(posedge clk);
		#2 Nrst = 1'b1;
	endtask

	task automatic load_image(input logic [63:0] pattern);
		for (int i = 0; i < `ROM_WORDS; i++) begin
			img_valid = 1'b1;
			img_wr.addr = `ROM_AW'(i);
			img_wr.data = image_word(pattern, i);
			@(negedge clk);
			while (!img_ready) @(negedge clk);
			@(posedge clk);
			#2;
		end
		img_valid = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
		@(posedge clk);
		#2;
		reg_valid = 1'b1;
		reg_wr.addr = addr;
		reg_wr.data = data;
		@(negedge clk);
		while (!reg_ready) @(negedge clk);
		@(posedge clk);
		#2 reg_valid = 1'b0;
	endtask

	task automatic read_word(input int addr, output logic [63:0] data);
		@(posedge clk);
		#2;
		rd_valid = 1'b1;
		rd_req.addr = `MEM_AW'(addr);
		@(negedge clk);
		while (!rd_ready) @(negedge clk);
		@(posedge clk);
		#2 rd_valid = 1'b0;
		accepted_cnt++;
		@(negedge clk);
		if (!rdata_valid)
			report_error($sformatf("no read data one cycle after accepting word %0h", addr));
		data = rdata;
	endtask

	// readback at random gaps until the core is released
	task automatic flood_reads_until_done(input int word_base, input int nwords);
		int gap;
		logic [63:0] got;
		while (core_rst_n !== 1'b1) begin
			gap = int'($urandom % 4);
			repeat (gap) @(posedge clk);
			read_word(word_base + int'($urandom % 32'(nwords)), got);
			flood_reads++;
		end
	endtask

	task automatic run_test(input int t);
		int idx;
		int count;
		int word_base;
		logic [15:0] base;
		logic rb;
		logic [63:0] pattern;
		logic [63:0] got;
		idx = 1 + t * REC_LEN;
		base = stim[idx][15:0];
		count = int'(stim[idx+1]);
		rb = stim[idx+2][0];
		pattern = stim[idx+3];
		word_base = int'(base) / 8;
		test_errors = 0;
		@(posedge clk);
		#2;
		apply_reset();
		accepted_cnt = 0;
		rdv_count = 0;
		flood_reads = 0;
		check_value("core_rst_n", 64'(core_rst_n), 64'd0);
		check_value("rdata_valid", 64'(rdata_valid), 64'd0);
		load_image(pattern);
		write_reg(2'd0, {16'h0, base});
		write_reg(2'd1, 32'(count));
		repeat (20) @(negedge clk);
		check_value("core_rst_n", 64'(core_rst_n), 64'd0);
		write_reg(2'd2, 32'd1);
		if (rb) begin
			fork
				wait (core_rst_n === 1'b1);
				flood_reads_until_done(word_base, count * 8);
			join
			if (flood_reads == 0)
				report_error("no readback was accepted while the preload ran");
		end else begin
			wait (core_rst_n === 1'b1);
		end
		for (int i = 0; i < count * 8; i++) begin
			read_word(word_base + i, got);
			check_value($sformatf("rdata[%0h]", word_base + i), got, image_word(pattern, i));
		end
		for (int k = 0; k < 4; k++) begin
			read_word(int'(stim[idx+4+2*k]), got);
			check_value($sformatf("rdata[%0h]", stim[idx+4+2*k]), got, stim[idx+5+2*k]);
		end
		repeat (3) @(negedge clk);
		check_value("rdata_valid count", 64'(rdv_count), 64'(accepted_cnt));
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d: %0d bursts at base %h, readback %0d, %s with %0d errors",
			t, count, base, rb, (test_errors == 0) ? "ok" : "bad", test_errors);
	endtask

	initial begin
		int n_tests;
		int beats;
		void'($urandom(47));
		apply_reset();
		$readmemh("testbench/boot_stim.txt", stim);
		n_tests = int'(stim[0]);
		beats = 0;
		if (n_tests < 1 || n_tests > (STIM_LEN - 1) / REC_LEN) begin
			report_error("stimulus file holds an invalid number of tests");
			n_tests = 0;
		end
		for (int t = 0; t < n_tests; t++)
			beats += int'(stim[1 + t * REC_LEN + 1]) * 8;
		wd_cycles = beats * 200 + 2000;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			n_tests, tests_failed, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
